// ==== cdc_clear_ctrl.f ====
rtl/clear_phase_pkg.sv
rtl/clear_fsm_pkg.sv
rtl/phase_cdc_src.sv
rtl/phase_cdc_dst.sv
rtl/clear_initiator.sv
rtl/clear_receiver.sv
rtl/clear_ctrl_half.sv
rtl/cdc_clear_ctrl.sv
tests/tb_cdc_clear_ctrl.sv

// ==== Makefile ====
# Verilator build of the clear controller and its testbench

TOP = tb_cdc_clear_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f cdc_clear_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing -f cdc_clear_ctrl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/clear_stimulus.txt ====
# name  request(reset|a|b|both)  ack_delay_a  ack_delay_b  min_a max_a  min_b max_b
# delays are in cycles of the own clock, -1 draws a long random delay
reset_seq    reset  3  5  1 2  1 2
a_only       a      2  4  1 1  1 1
b_only       b      4  2  1 1  1 1
a_fast_ack   a      0  0  1 1  1 1
b_fast_ack   b      0  0  1 1  1 1
a_random     a     -1 -1  1 1  1 1
b_random     b     -1 -1  1 1  1 1
a_slow_ack   a     40  7  1 1  1 1
both_req     both   3  3  1 2  1 2
both_random  both  -1 -1  1 2  1 2

// ==== tests/tb_cdc_clear_ctrl.sv ====
// testbench with two clocks, acknowledge responders, a stimulus file reader and checks

`timescale 1ns/1ps

module tb_cdc_clear_ctrl
  import clear_phase_pkg::*;
;

  localparam int unsigned MAX_TESTS = 32;
  localparam int unsigned TIMEOUT   = 2000;

  logic a_clk_i, a_rst_ni, a_clear_i, a_isolate_ack_i, a_clear_ack_i;
  logic b_clk_i, b_rst_ni, b_clear_i, b_isolate_ack_i, b_clear_ack_i;
  logic a_isolate_o, a_clear_o, b_isolate_o, b_clear_o;

  // test table read from the stimulus file
  string       names [MAX_TESTS];
  string       reqs [MAX_TESTS];
  int          dly_tab_a [MAX_TESTS];
  int          dly_tab_b [MAX_TESTS];
  int unsigned min_a [MAX_TESTS];
  int unsigned max_a [MAX_TESTS];
  int unsigned min_b [MAX_TESTS];
  int unsigned max_b [MAX_TESTS];
  int          n_tests;

  string        cur_test;
  int           dly_a, dly_b;
  integer       seed;
  int unsigned  value_errors, protocol_errors, timeout_errors;
  // index 0 is side a and index 1 is side b
  int unsigned  iso_cnt [2];
  int unsigned  clr_cnt [2];
  logic         prev_iso [2];
  logic         prev_clr [2];
  logic         prev_clr_ack [2];
  clear_phase_e last_ph [2];
  int           a_iso_wait, a_clr_wait, b_iso_wait, b_clr_wait;

  cdc_clear_ctrl #(
    .SYNC_STAGES          ( 2    ),
    .CLEAR_ON_ASYNC_RESET ( 1'b1 )
  ) DUT (
    .a_clk_i         ( a_clk_i         ),
    .a_rst_ni        ( a_rst_ni        ),
    .a_clear_i       ( a_clear_i       ),
    .a_isolate_ack_i ( a_isolate_ack_i ),
    .a_clear_ack_i   ( a_clear_ack_i   ),
    .a_isolate_o     ( a_isolate_o     ),
    .a_clear_o       ( a_clear_o       ),
    .b_clk_i         ( b_clk_i         ),
    .b_rst_ni        ( b_rst_ni        ),
    .b_clear_i       ( b_clear_i       ),
    .b_isolate_ack_i ( b_isolate_ack_i ),
    .b_clear_ack_i   ( b_clear_ack_i   ),
    .b_isolate_o     ( b_isolate_o     ),
    .b_clear_o       ( b_clear_o       )
  );

  // rising edges of a fall on 10+20k ns and those of b on 15+30k ns, so they never meet
  always #10 a_clk_i = ~a_clk_i;
  always #15 b_clk_i = ~b_clk_i;

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s: %s expected %0b actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int unsigned lo, input int unsigned hi,
                             input int unsigned act);
    if (act < lo || act > hi) begin
      value_errors++;
      $display("error %s: %s expected %0d..%0d actual %0d", cur_test, what, lo, hi, act);
    end
  endtask

  task automatic check_phase(input string what, input clear_phase_e exp,
                             input clear_phase_e act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s: %s expected %s actual %s", cur_test, what, exp.name(), act.name());
    end
  endtask

  // a negative delay asks for a long random acknowledge delay
  function automatic int pick_delay(input int d);
    if (d < 0) begin
      return int'({$random(seed)} % 32'd48) + 16;
    end
    return d;
  endfunction

  // --------------------------------------------------------------------------
  // output monitor, one call per side and clock edge
  // --------------------------------------------------------------------------

  task automatic observe_side(input int s, input logic rst_n, input logic iso, input logic clr,
                              input logic iso_ack, input logic clr_ack);
    string side;
    side = (s == 0) ? "a" : "b";
    if (!rst_n) begin
      prev_iso[s]     = 1'b0;
      prev_clr[s]     = 1'b0;
      prev_clr_ack[s] = 1'b0;
      last_ph[s]      = IDLE;
    end else begin
      if (clr && !prev_clr[s]) begin
        clr_cnt[s]++;
        if (!(iso && iso_ack)) begin
          protocol_errors++;
          $display("side %s clear_o rose without isolate_o and isolate_ack_i in test %s",
                   side, cur_test);
        end
      end
      if (clr && !iso) begin
        protocol_errors++;
        $display("side %s clear_o is high while isolate_o is low in test %s", side, cur_test);
      end
      // the acknowledge seen one edge earlier is what let clear drop
      if (!clr && prev_clr[s]) begin
        check_flag({"clear_ack_i before clear_o falls on ", side}, 1'b1, prev_clr_ack[s]);
      end
      if (iso && !prev_iso[s]) begin
        iso_cnt[s]++;
      end
      if (!iso && prev_iso[s]) begin
        check_phase({"last phase before isolate_o falls on ", side}, POST_CLEAR, last_ph[s]);
      end
      // phase as seen from the outputs alone
      if (!iso) begin
        last_ph[s] = IDLE;
      end else if (clr) begin
        last_ph[s] = CLEAR;
      end else if (last_ph[s] == CLEAR || last_ph[s] == POST_CLEAR) begin
        last_ph[s] = POST_CLEAR;
      end else begin
        last_ph[s] = ISOLATE;
      end
      prev_iso[s]     = iso;
      prev_clr[s]     = clr;
      prev_clr_ack[s] = clr_ack;
    end
  endtask

  always @(posedge a_clk_i) begin
    observe_side(0, a_rst_ni, a_isolate_o, a_clear_o, a_isolate_ack_i, a_clear_ack_i);
  end

  always @(posedge b_clk_i) begin
    observe_side(1, b_rst_ni, b_isolate_o, b_clear_o, b_isolate_ack_i, b_clear_ack_i);
  end

  // --------------------------------------------------------------------------
  // acknowledge responders
  // --------------------------------------------------------------------------

  // each acknowledge follows its output after a delay and drops with it
  always @(posedge a_clk_i) begin
    if (!a_rst_ni || !a_isolate_o) begin
      a_isolate_ack_i <= 1'b0;
      a_iso_wait      <= pick_delay(dly_a);
    end else if (!a_isolate_ack_i) begin
      if (a_iso_wait <= 0) a_isolate_ack_i <= 1'b1;
      else a_iso_wait <= a_iso_wait - 1;
    end
    if (!a_rst_ni || !a_clear_o) begin
      a_clear_ack_i <= 1'b0;
      a_clr_wait    <= pick_delay(dly_a);
    end else if (!a_clear_ack_i) begin
      if (a_clr_wait <= 0) a_clear_ack_i <= 1'b1;
      else a_clr_wait <= a_clr_wait - 1;
    end
  end

  always @(posedge b_clk_i) begin
    if (!b_rst_ni || !b_isolate_o) begin
      b_isolate_ack_i <= 1'b0;
      b_iso_wait      <= pick_delay(dly_b);
    end else if (!b_isolate_ack_i) begin
      if (b_iso_wait <= 0) b_isolate_ack_i <= 1'b1;
      else b_iso_wait <= b_iso_wait - 1;
    end
    if (!b_rst_ni || !b_clear_o) begin
      b_clear_ack_i <= 1'b0;
      b_clr_wait    <= pick_delay(dly_b);
    end else if (!b_clear_ack_i) begin
      if (b_clr_wait <= 0) b_clear_ack_i <= 1'b1;
      else b_clr_wait <= b_clr_wait - 1;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus and waits
  // --------------------------------------------------------------------------

  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    fd      = $fopen("tests/clear_stimulus.txt", "r");
    n_tests = 0;
    if (fd == 0) begin
      $display("cannot open the stimulus file tests/clear_stimulus.txt");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %s %d %d %d %d %d %d", names[n_tests], reqs[n_tests],
                      dly_tab_a[n_tests], dly_tab_b[n_tests], min_a[n_tests],
                      max_a[n_tests], min_b[n_tests], max_b[n_tests]);
        if (cnt == 8) n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic pulse_a();
    @(posedge a_clk_i);
    a_clear_i <= 1'b1;
    @(posedge a_clk_i);
    a_clear_i <= 1'b0;
  endtask

  task automatic pulse_b();
    @(posedge b_clk_i);
    b_clear_i <= 1'b1;
    @(posedge b_clk_i);
    b_clear_i <= 1'b0;
  endtask

  // both sides must show an isolate period newer than the given counts
  task automatic wait_for_start(input int unsigned base_a, input int unsigned base_b,
                                output bit ok);
    ok = 1'b0;
    for (int unsigned i = 0; i < TIMEOUT && !ok; i++) begin
      @(posedge a_clk_i);
      ok = (iso_cnt[0] > base_a) && (iso_cnt[1] > base_b);
    end
    if (!ok) begin
      timeout_errors++;
      $display("test %s timed out waiting for isolate_o to rise on both sides", cur_test);
    end
  endtask

  task automatic wait_for_idle(output bit ok);
    ok = 1'b0;
    for (int unsigned i = 0; i < TIMEOUT && !ok; i++) begin
      @(posedge a_clk_i);
      ok = !a_isolate_o && !b_isolate_o && !a_clear_o && !b_clear_o;
    end
    if (!ok) begin
      timeout_errors++;
      $display("test %s timed out waiting for both sides to finish the sequence", cur_test);
    end
  endtask

  initial begin
    int unsigned base_a, base_b;
    int unsigned clr_base_a, clr_base_b;
    bit          ok;
    a_clk_i = 1'b0;
    b_clk_i = 1'b0;
    a_rst_ni = 1'b0;
    b_rst_ni = 1'b0;
    a_clear_i = 1'b0;
    b_clear_i = 1'b0;
    a_isolate_ack_i = 1'b0;
    a_clear_ack_i = 1'b0;
    b_isolate_ack_i = 1'b0;
    b_clear_ack_i = 1'b0;
    seed = 32'ha52f;
    value_errors = 0;
    protocol_errors = 0;
    timeout_errors = 0;
    iso_cnt[0] = 0;
    iso_cnt[1] = 0;
    clr_cnt[0] = 0;
    clr_cnt[1] = 0;
    dly_a = 1;
    dly_b = 1;
    cur_test = "setup";
    load_stimulus();
    if (n_tests == 0) begin
      protocol_errors++;
      $display("no test was read from the stimulus file");
    end
    ok = 1'b1;
    for (int i = 0; i < n_tests && ok; i++) begin
      cur_test   = names[i];
      dly_a      = dly_tab_a[i];
      dly_b      = dly_tab_b[i];
      base_a     = iso_cnt[0];
      base_b     = iso_cnt[1];
      clr_base_a = clr_cnt[0];
      clr_base_b = clr_cnt[1];
      if (reqs[i] == "reset") begin
        // resets are held from time zero for 4 cycles of clock a
        repeat (4) @(posedge a_clk_i);
        a_rst_ni <= 1'b1;
        b_rst_ni <= 1'b1;
        @(posedge a_clk_i);
        check_flag("isolate_o on a after reset", 1'b1, a_isolate_o);
        check_flag("isolate_o on b after reset", 1'b1, b_isolate_o);
      end else if (reqs[i] == "a") begin
        pulse_a();
      end else if (reqs[i] == "b") begin
        pulse_b();
      end else begin
        fork
          pulse_a();
          pulse_b();
        join
      end
      wait_for_start(base_a, base_b, ok);
      if (ok) wait_for_idle(ok);
      if (ok) begin
        // let the last edges reach both monitors
        repeat (4) @(posedge b_clk_i);
        check_count("isolate periods on a", 1, 1, iso_cnt[0] - base_a);
        check_count("isolate periods on b", 1, 1, iso_cnt[1] - base_b);
        check_count("clear pulses on a", min_a[i], max_a[i], clr_cnt[0] - clr_base_a);
        check_count("clear pulses on b", min_b[i], max_b[i], clr_cnt[1] - clr_base_b);
        check_flag("clear_o on a at the end", 1'b0, a_clear_o);
        check_flag("clear_o on b at the end", 1'b0, b_clear_o);
        check_phase("final phase on a", IDLE, last_ph[0]);
        check_phase("final phase on b", IDLE, last_ph[1]);
      end
    end
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== rtl/cdc_clear_ctrl.sv ====
// top level of the clear controller spanning the a and b clock domains

`timescale 1ns/1ps

module cdc_clear_ctrl
  import clear_phase_pkg::*;
  import clear_fsm_pkg::*;
#(
  // depth of every req and ack synchronizer, at least 2
  parameter int unsigned SYNC_STAGES          = $bits(sync_reg_t),
  parameter bit          CLEAR_ON_ASYNC_RESET = 1'b1
) (
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  input  logic a_isolate_ack_i,
  input  logic a_clear_ack_i,
  output logic a_isolate_o,
  output logic a_clear_o,
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  input  logic b_isolate_ack_i,
  input  logic b_clear_ack_i,
  output logic b_isolate_o,
  output logic b_clear_o
);

  // asynchronous wires between the two domains
  logic         a2b_req, b2a_ack;
  logic         b2a_req, a2b_ack;
  clear_phase_e a2b_phase, b2a_phase;

  clear_ctrl_half #(
    .SYNC_STAGES          ( SYNC_STAGES          ),
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) u_half_a (
    .clk_i         ( a_clk_i         ),
    .rst_ni        ( a_rst_ni        ),
    .clear_i       ( a_clear_i       ),
    .isolate_ack_i ( a_isolate_ack_i ),
    .clear_ack_i   ( a_clear_ack_i   ),
    .isolate_o     ( a_isolate_o     ),
    .clear_o       ( a_clear_o       ),
    .async_req_o   ( a2b_req         ),
    .async_ack_i   ( b2a_ack         ),
    .async_phase_o ( a2b_phase       ),
    .async_req_i   ( b2a_req         ),
    .async_ack_o   ( a2b_ack         ),
    .async_phase_i ( b2a_phase       )
  );

  // side b is wired as the mirror image of side a
  clear_ctrl_half #(
    .SYNC_STAGES          ( SYNC_STAGES          ),
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) u_half_b (
    .clk_i         ( b_clk_i         ),
    .rst_ni        ( b_rst_ni        ),
    .clear_i       ( b_clear_i       ),
    .isolate_ack_i ( b_isolate_ack_i ),
    .clear_ack_i   ( b_clear_ack_i   ),
    .isolate_o     ( b_isolate_o     ),
    .clear_o       ( b_clear_o       ),
    .async_req_o   ( b2a_req         ),
    .async_ack_i   ( a2b_ack         ),
    .async_phase_o ( b2a_phase       ),
    .async_req_i   ( a2b_req         ),
    .async_ack_o   ( b2a_ack         ),
    .async_phase_i ( a2b_phase       )
  );

endmodule

// ==== rtl/clear_ctrl_half.sv ====
// one side of the clear controller joining the initiating and the following path

`timescale 1ns/1ps

module clear_ctrl_half
  import clear_phase_pkg::*;
#(
  parameter int unsigned SYNC_STAGES          = 2,
  parameter bit          CLEAR_ON_ASYNC_RESET = 1'b1
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  input  logic         clear_ack_i,
  output logic         isolate_o,
  output logic         clear_o,
  // wires to and from the other clock domain
  output logic         async_req_o,
  input  logic         async_ack_i,
  output clear_phase_e async_phase_o,
  input  logic         async_req_i,
  output logic         async_ack_o,
  input  clear_phase_e async_phase_i
);

  logic         init_valid, init_ready, init_isolate, init_clear;
  clear_phase_e init_phase;
  logic         recv_valid, recv_accept, recv_isolate, recv_clear;
  clear_phase_e recv_phase;

  // --------------------------------------------------------------------------
  // initiating path
  // --------------------------------------------------------------------------

  clear_initiator #(
    .CLEAR_ON_ASYNC_RESET ( CLEAR_ON_ASYNC_RESET )
  ) u_initiator (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .isolate_ack_i ( isolate_ack_i ),
    .clear_ack_i   ( clear_ack_i   ),
    .phase_ready_i ( init_ready    ),
    .phase_valid_o ( init_valid    ),
    .phase_o       ( init_phase    ),
    .isolate_o     ( init_isolate  ),
    .clear_o       ( init_clear    )
  );

  // the reset message is sent only when a reset starts a sequence
  phase_cdc_src #(
    .SYNC_STAGES    ( SYNC_STAGES          ),
    .SEND_RESET_MSG ( CLEAR_ON_ASYNC_RESET )
  ) u_cdc_src (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .phase_i       ( init_phase    ),
    .valid_i       ( init_valid    ),
    .ready_o       ( init_ready    ),
    .async_ack_i   ( async_ack_i   ),
    .async_req_o   ( async_req_o   ),
    .async_phase_o ( async_phase_o )
  );

  // --------------------------------------------------------------------------
  // following path
  // --------------------------------------------------------------------------

  phase_cdc_dst #(
    .SYNC_STAGES ( SYNC_STAGES )
  ) u_cdc_dst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .accept_i      ( recv_accept   ),
    .valid_o       ( recv_valid    ),
    .phase_o       ( recv_phase    ),
    .async_req_i   ( async_req_i   ),
    .async_phase_i ( async_phase_i ),
    .async_ack_o   ( async_ack_o   )
  );

  clear_receiver u_receiver (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .valid_i       ( recv_valid    ),
    .phase_i       ( recv_phase    ),
    .isolate_ack_i ( isolate_ack_i ),
    .clear_ack_i   ( clear_ack_i   ),
    .accept_o      ( recv_accept   ),
    .isolate_o     ( recv_isolate  ),
    .clear_o       ( recv_clear    )
  );

  // both paths step through the same order so their OR keeps that order
  // when the two sides start a sequence at the same time
  assign isolate_o = init_isolate | recv_isolate;
  assign clear_o   = init_clear | recv_clear;

endmodule

// ==== rtl/clear_receiver.sv ====
// receiver that mirrors the phases of the far side and acknowledges each one locally

`timescale 1ns/1ps

module clear_receiver
  import clear_phase_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         valid_i,
  input  clear_phase_e phase_i,
  input  logic         isolate_ack_i,
  input  logic         clear_ack_i,
  output logic         accept_o,
  output logic         isolate_o,
  output logic         clear_o
);

  // last phase that was handed over by the far side
  clear_phase_e phase_q;
  // phase the outputs are decoded from in this cycle
  clear_phase_e cur_phase;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= IDLE;
    end else if (valid_i && accept_o) begin
      phase_q <= phase_i;
    end
  end

  // a pending phase drives the outputs at once, even before it is accepted
  assign cur_phase = valid_i ? phase_i : phase_q;

  always_comb begin
    isolate_o = 1'b0;
    clear_o   = 1'b0;
    accept_o  = 1'b0;
    case (cur_phase)
      ISOLATE: begin
        isolate_o = 1'b1;
        // far initiator stalls until the local side is isolated
        accept_o  = valid_i && isolate_ack_i;
      end
      CLEAR: begin
        isolate_o = 1'b1;
        clear_o   = 1'b1;
        accept_o  = valid_i && clear_ack_i;
      end
      POST_CLEAR: begin
        isolate_o = 1'b1;
        accept_o  = valid_i;
      end
      default: begin
        accept_o = valid_i;
      end
    endcase
  end

endmodule

// ==== rtl/clear_initiator.sv ====
// initiator state machine that starts a local clear sequence and offers each phase

`timescale 1ns/1ps

module clear_initiator
  import clear_phase_pkg::*;
  import clear_fsm_pkg::*;
#(
  parameter bit CLEAR_ON_ASYNC_RESET = 1'b1
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  input  logic         clear_ack_i,
  input  logic         phase_ready_i,
  output logic         phase_valid_o,
  output clear_phase_e phase_o,
  output logic         isolate_o,
  output logic         clear_o
);

  // both packages name their values alike so every literal is qualified
  init_state_e state_d, state_q;

  // --------------------------------------------------------------------------
  // next state and outputs
  // --------------------------------------------------------------------------

  always_comb begin
    state_d       = state_q;
    phase_valid_o = 1'b0;
    phase_o       = clear_phase_pkg::IDLE;
    isolate_o     = 1'b0;
    clear_o       = 1'b0;
    case (state_q)
      clear_fsm_pkg::IDLE: begin
        if (clear_i) begin
          state_d = clear_fsm_pkg::ISOLATE;
        end
      end
      clear_fsm_pkg::ISOLATE: begin
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::ISOLATE;
        isolate_o     = 1'b1;
        // crossing and local acknowledge may finish in either order
        if (phase_ready_i && isolate_ack_i) begin
          state_d = clear_fsm_pkg::CLEAR;
        end else if (phase_ready_i) begin
          state_d = clear_fsm_pkg::WAIT_ISOLATE_ACK;
        end else if (isolate_ack_i) begin
          state_d = clear_fsm_pkg::WAIT_ISOLATE_PHASE_ACK;
        end
      end
      clear_fsm_pkg::WAIT_ISOLATE_PHASE_ACK: begin
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::ISOLATE;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = clear_fsm_pkg::CLEAR;
        end
      end
      clear_fsm_pkg::WAIT_ISOLATE_ACK: begin
        phase_o   = clear_phase_pkg::ISOLATE;
        isolate_o = 1'b1;
        if (isolate_ack_i) begin
          state_d = clear_fsm_pkg::CLEAR;
        end
      end
      clear_fsm_pkg::CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::CLEAR;
        isolate_o     = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i && clear_ack_i) begin
          state_d = clear_fsm_pkg::POST_CLEAR;
        end else if (phase_ready_i) begin
          state_d = clear_fsm_pkg::WAIT_CLEAR_ACK;
        end else if (clear_ack_i) begin
          state_d = clear_fsm_pkg::WAIT_CLEAR_PHASE_ACK;
        end
      end
      clear_fsm_pkg::WAIT_CLEAR_PHASE_ACK: begin
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::CLEAR;
        isolate_o     = 1'b1;
        clear_o       = 1'b1;
        if (phase_ready_i) begin
          state_d = clear_fsm_pkg::POST_CLEAR;
        end
      end
      clear_fsm_pkg::WAIT_CLEAR_ACK: begin
        phase_o   = clear_phase_pkg::CLEAR;
        isolate_o = 1'b1;
        clear_o   = 1'b1;
        if (clear_ack_i) begin
          state_d = clear_fsm_pkg::POST_CLEAR;
        end
      end
      clear_fsm_pkg::POST_CLEAR: begin
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::POST_CLEAR;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = clear_fsm_pkg::FINISHED;
        end
      end
      clear_fsm_pkg::FINISHED: begin
        // isolate is held until the far side has returned to IDLE as well
        phase_valid_o = 1'b1;
        phase_o       = clear_phase_pkg::IDLE;
        isolate_o     = 1'b1;
        if (phase_ready_i) begin
          state_d = clear_fsm_pkg::IDLE;
        end
      end
      default: begin
        state_d = clear_fsm_pkg::ISOLATE;
      end
    endcase
  end

  // a reset may itself count as a clear request and start in ISOLATE
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CLEAR_ON_ASYNC_RESET ? clear_fsm_pkg::ISOLATE : clear_fsm_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== rtl/phase_cdc_dst.sv ====
// destination half of the 4-phase crossing that presents a received clear phase

`timescale 1ns/1ps

module phase_cdc_dst
  import clear_phase_pkg::*;
#(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         accept_i,
  output logic         valid_o,
  output clear_phase_e phase_o,
  input  logic         async_req_i,
  input  clear_phase_e async_phase_i,
  output logic         async_ack_o
);

  typedef enum logic [1:0] {
    DST_IDLE,
    DST_VALID,
    DST_WAIT_REQ_LO
  } dst_state_e;

  dst_state_e             state_d, state_q;
  logic                   ack_d, ack_q;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_synced;
  clear_phase_e           phase_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], async_req_i};
    end
  end

  assign req_synced = req_sync_q[SYNC_STAGES-1];

  // the phase wires settled before req rose so they are sampled here once
  always_ff @(posedge clk_i) begin
    if (state_q == DST_IDLE && req_synced) begin
      phase_q <= async_phase_i;
    end
  end

  always_comb begin
    state_d = state_q;
    ack_d   = ack_q;
    case (state_q)
      DST_IDLE: begin
        if (req_synced) begin
          state_d = DST_VALID;
        end
      end
      DST_VALID: begin
        // the phase stays on offer until the local receiver takes it
        if (accept_i) begin
          ack_d   = 1'b1;
          state_d = DST_WAIT_REQ_LO;
        end
      end
      DST_WAIT_REQ_LO: begin
        if (!req_synced) begin
          ack_d   = 1'b0;
          state_d = DST_IDLE;
        end
      end
      default: begin
        state_d = DST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  assign valid_o     = (state_q == DST_VALID);
  assign phase_o     = phase_q;
  assign async_ack_o = ack_q;

endmodule

// ==== rtl/phase_cdc_src.sv ====
// source half of the 4-phase crossing that hands one clear phase to the other domain

`timescale 1ns/1ps

module phase_cdc_src
  import clear_phase_pkg::*;
#(
  parameter int unsigned SYNC_STAGES    = 2,
  parameter bit          SEND_RESET_MSG = 1'b0
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         valid_i,
  output logic         ready_o,
  input  logic         async_ack_i,
  output logic         async_req_o,
  output clear_phase_e async_phase_o
);

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WAIT_ACK_HI,
    SRC_WAIT_ACK_LO
  } src_state_e;

  src_state_e             state_d, state_q;
  logic                   req_d, req_q;
  clear_phase_e           phase_d, phase_q;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_synced;

  // ack comes from the other clock domain and passes a plain flop chain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], async_ack_i};
    end
  end

  assign ack_synced = ack_sync_q[SYNC_STAGES-1];

  // the phase is only taken while idle so it stays stable under a high req
  // ready is given once the full req/ack round trip has closed
  always_comb begin
    state_d = state_q;
    req_d   = req_q;
    phase_d = phase_q;
    ready_o = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (valid_i) begin
          phase_d = phase_i;
          req_d   = 1'b1;
          state_d = SRC_WAIT_ACK_HI;
        end
      end
      SRC_WAIT_ACK_HI: begin
        // destination accepted the phase so the request can be withdrawn
        if (ack_synced) begin
          req_d   = 1'b0;
          state_d = SRC_WAIT_ACK_LO;
        end
      end
      SRC_WAIT_ACK_LO: begin
        if (!ack_synced) begin
          ready_o = 1'b1;
          state_d = SRC_IDLE;
        end
      end
      default: begin
        state_d = SRC_IDLE;
      end
    endcase
  end

  // with the reset message the far side already sees ISOLATE while this
  // side is still held in reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEND_RESET_MSG ? SRC_WAIT_ACK_HI : SRC_IDLE;
      req_q   <= SEND_RESET_MSG;
      phase_q <= SEND_RESET_MSG ? ISOLATE : IDLE;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
      phase_q <= phase_d;
    end
  end

  assign async_req_o   = req_q;
  assign async_phase_o = phase_q;

endmodule

// ==== rtl/clear_fsm_pkg.sv ====
// initiator state encoding and the synchronizer register type of the side logic

package clear_fsm_pkg;

  // --------------------------------------------------------------------------
  // initiator state machine
  // --------------------------------------------------------------------------

  // the WAIT states cover the case where the crossing and the local
  // acknowledge do not complete in the same cycle
  typedef enum logic [3:0] {
    IDLE,
    ISOLATE,
    WAIT_ISOLATE_PHASE_ACK,
    WAIT_ISOLATE_ACK,
    CLEAR,
    WAIT_CLEAR_PHASE_ACK,
    WAIT_CLEAR_ACK,
    POST_CLEAR,
    FINISHED
  } init_state_e;

  // default depth of a req or ack synchronizer, one bit per flop
  // the top level takes its default synchronizer depth from this width
  typedef logic [1:0] sync_reg_t;

endpackage

// ==== rtl/clear_phase_pkg.sv ====
// phase encoding of the clear sequence and its width on the crossing wires

package clear_phase_pkg;

  // --------------------------------------------------------------------------
  // phase word
  // --------------------------------------------------------------------------

  // number of bits of the phase word carried between the two clock domains
  localparam int unsigned PHASE_W = 2;

  // one clear sequence walks through ISOLATE, CLEAR and POST_CLEAR in order
  // and then returns to IDLE
  // the far side mirrors each phase only after it has been handed over
  typedef enum logic [PHASE_W-1:0] {
    // normal operation with isolate and clear both low
    IDLE       = 2'd0,
    // isolate is raised and the side waits for its isolate acknowledge
    ISOLATE    = 2'd1,
    // clear is raised on top of isolate
    CLEAR      = 2'd2,
    // clear has dropped again while isolate is still held
    POST_CLEAR = 2'd3
  } clear_phase_e;

endpackage
